// File: build.f
+incdir+include
verilog/barrel_pkg.sv
verilog/thread_counter.sv
verilog/thread_stage_addressing.sv
verilog/thread_state_ram.sv
verilog/state_write_arbiter.sv
verilog/block_count_pipeline.sv
verilog/barrel_block_counter_top.sv
verif/block_counter_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the block counter testbench with Verilator and run it.
# The simulator's exit status is the result of the run.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    -f build.f \
    --top-module block_counter_tb \
    -o block_counter_sim

./obj_dir/block_counter_sim

// File: verif/block_counter_tb.sv
// Testbench for the barrel block counter
// Count model, LFSR stimulus, compare tasks, directed tests and timeout

`default_nettype none

`include "barrel_config.svh"

module block_counter_tb
    import barrel_pkg::*;
();

    localparam int          THREADS        = `BARREL_THREAD_COUNT;
    localparam int          INITIAL        = `BARREL_INITIAL_THREAD;
    localparam int          CLOCK_HALF     = 20;
    localparam int          DRIVE_DELAY    = 2;
    localparam int          RESET_CYCLES   = 5;
    localparam int          COUNT_CYCLES   = 400;
    localparam int          TIMEOUT_CYCLES = 1200;   // About 530 cycles of tests plus margin
    localparam logic [15:0] LFSR_SEED      = 16'd37824;
    localparam thread_id_t  WRAP_THREAD    = thread_id_t'(3);
    localparam thread_id_t  CONTEND_THREAD = thread_id_t'(6);

    logic          clock;
    logic          rst_n;
    logic          block_end;
    logic          load;
    thread_id_t    load_thread;
    block_count_t  load_count;
    thread_id_t    read_thread_bbc;
    logic          load_pending;
    count_report_t report;

    block_count_t  model [THREADS];    // Expected count per thread
    block_count_t  loaded [THREADS];   // Values written by the host
    thread_id_t    bbc_hist [3];       // Block-counter threads, newest first
    int            hist_len;
    logic          count_checks;       // Model is in step with the RAM
    logic          valid_seen;
    logic [15:0]   lfsr_state;
    int            cycle_count = 0;

    barrel_block_counter_top uut (
        .clock           (clock),
        .rst_n           (rst_n),
        .block_end       (block_end),
        .load            (load),
        .load_thread     (load_thread),
        .load_count      (load_count),
        .read_thread_bbc (read_thread_bbc),
        .load_pending    (load_pending),
        .report          (report)
    );

    initial begin
        clock = 1'b0;
        forever #CLOCK_HALF clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run went past %0d clock cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    // ==============================
    // Helpers and compare tasks
    // ==============================

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_count(input string test, input block_count_t expected,
                               input block_count_t actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %0h, actual %0h", test, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_thread(input string test, input thread_id_t expected,
                                input thread_id_t actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %0d, actual %0d", test, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_flag(input string test, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %b, actual %b", test, expected, actual);
            abort_run();
        end
    endtask

    // Thread a number of steps along the rotation
    function automatic thread_id_t thread_after(input thread_id_t t, input int steps);
        return thread_id_t'((int'(t) + steps + THREADS) % THREADS);
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int count, output logic [15:0] bits);
        int i;
        bits = '0;
        for (i = 0; i < count; i++) begin
            bits       = {bits[14:0], lfsr_state[15]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // Mid-cycle look at the outputs, all stable here
    task automatic observe_cycle(input string test);
        thread_id_t bbc_now;
        bbc_now = read_thread_bbc;
        if (hist_len > 0) begin
            check_thread({test, " rotation"}, thread_after(bbc_hist[0], 1), bbc_now);
        end
        if (report.valid) begin
            valid_seen = 1'b1;
            if (hist_len >= 3) begin
                check_thread({test, " report thread"}, bbc_hist[2], report.thread);
            end
        end else if (valid_seen) begin
            $display("Report valid went low again during %s", test);
            abort_run();
        end
        if (block_end) begin
            model[bbc_now] = model[bbc_now] + block_count_t'(1);   // Shows up 3 cycles later
        end
        if (count_checks && report.valid) begin
            check_count(test, model[report.thread], report.count);
        end
        bbc_hist[2] = bbc_hist[1];
        bbc_hist[1] = bbc_hist[0];
        bbc_hist[0] = bbc_now;
        if (hist_len < 3) begin
            hist_len++;
        end
    endtask

    task automatic drive_cycle(input logic be, input logic ld, input thread_id_t lt,
                               input block_count_t lc, input string test);
        @(posedge clock);
        #DRIVE_DELAY;
        block_end   = be;
        load        = ld;
        load_thread = lt;
        load_count  = lc;
        @(negedge clock);
        observe_cycle(test);
    endtask

    task automatic idle_cycles(input int count, input string test);
        repeat (count) drive_cycle(1'b0, 1'b0, '0, '0, test);
    endtask

    // ==============================
    // Directed tests
    // ==============================

    task automatic test_reset_state();
        int i;
        repeat (RESET_CYCLES - 1) @(posedge clock);
        @(negedge clock);
        check_flag("reset valid", 1'b0, report.valid);
        check_flag("reset pending", 1'b0, load_pending);
        @(posedge clock);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        @(negedge clock);
        // Block-counter stage trails the current thread by four
        check_thread("reset thread", thread_after(thread_id_t'(INITIAL), -4), read_thread_bbc);
        check_flag("reset valid", 1'b0, report.valid);
        check_flag("reset pending", 1'b0, load_pending);
        observe_cycle("reset");
        for (i = 1; i < 8; i++) begin
            idle_cycles(1, "reset");
            check_flag("reset valid", i >= 4, report.valid);   // Pipeline full after 4
        end
    endtask

    task automatic test_host_load();
        logic [15:0] bits;
        int t;
        count_checks = 1'b0;
        for (t = 0; t < THREADS; t++) begin
            draw_bits(16, bits);
            loaded[t] = bits;
            drive_cycle(1'b0, 1'b1, thread_id_t'(t), loaded[t], "host load");
            idle_cycles(1, "host load");
            check_flag("host load pending", 1'b1, load_pending);
            idle_cycles(1, "host load");
            check_flag("host load written", 1'b0, load_pending);
        end
        idle_cycles(12, "host load");   // Last thread read back and reported
        for (t = 0; t < THREADS; t++) begin
            idle_cycles(1, "host load");
            check_flag("host load valid", 1'b1, report.valid);
            check_count("host load", loaded[report.thread], report.count);
        end
        for (t = 0; t < THREADS; t++) begin
            model[t] = loaded[t];
        end
        count_checks = 1'b1;
    endtask

    task automatic test_counting();
        logic [15:0] bit_val;
        repeat (COUNT_CYCLES) begin
            draw_bits(1, bit_val);
            drive_cycle(bit_val[0], 1'b0, '0, '0, "counting");
        end
    endtask

    task automatic test_wrap();
        idle_cycles(4, "wrap");   // Let the last write-backs drain
        count_checks = 1'b0;
        drive_cycle(1'b0, 1'b1, WRAP_THREAD, '1, "wrap");
        idle_cycles(1, "wrap");
        check_flag("wrap pending", 1'b1, load_pending);
        idle_cycles(1, "wrap");
        check_flag("wrap written", 1'b0, load_pending);
        idle_cycles(12, "wrap");
        model[WRAP_THREAD] = '1;
        count_checks = 1'b1;
        while (thread_after(read_thread_bbc, 1) != WRAP_THREAD) begin
            idle_cycles(1, "wrap");
        end
        drive_cycle(1'b1, 1'b0, '0, '0, "wrap");
        check_thread("wrap block end", WRAP_THREAD, read_thread_bbc);
        idle_cycles(3, "wrap");
        check_thread("wrap report thread", WRAP_THREAD, report.thread);
        check_count("wrap", '0, report.count);   // All ones plus one
    endtask

    task automatic test_contention();
        logic [15:0] bits;
        int waited;
        int i;
        logic found;
        count_checks = 1'b0;
        draw_bits(16, bits);
        repeat (4) drive_cycle(1'b1, 1'b0, '0, '0, "contention");   // Write port now busy
        drive_cycle(1'b1, 1'b1, CONTEND_THREAD, bits, "contention");
        repeat (20) begin
            drive_cycle(1'b1, 1'b0, '0, '0, "contention");
            check_flag("contention pending", 1'b1, load_pending);
        end
        waited = 0;
        while (load_pending) begin
            if (waited == 8) begin
                $display("Host load still pending %0d cycles after block_end dropped", waited);
                abort_run();
            end
            idle_cycles(1, "contention");
            waited++;
        end
        idle_cycles(4, "contention");   // Reads from before the write
        found = 1'b0;
        for (i = 0; i < THREADS && !found; i++) begin
            idle_cycles(1, "contention");
            if (report.thread == CONTEND_THREAD) begin
                check_count("contention", bits, report.count);
                found = 1'b1;
            end
        end
        if (!found) begin
            $display("No report for the loaded thread after the contended load");
            abort_run();
        end
    endtask

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        rst_n        = 1'b0;
        block_end    = 1'b0;
        load         = 1'b0;
        load_thread  = '0;
        load_count   = '0;
        lfsr_state   = LFSR_SEED;
        hist_len     = 0;
        count_checks = 1'b0;
        valid_seen   = 1'b0;
        for (int t = 0; t < THREADS; t++) begin
            model[t]  = '0;
            loaded[t] = '0;
        end

        test_reset_state();
        test_host_load();
        test_counting();
        test_wrap();
        test_contention();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/barrel_block_counter_top.sv
// Barrel thread sequencer with per-thread basic-block counting
// Stage addressing, state memory, write arbiter and count pipeline

`default_nettype none

module barrel_block_counter_top
    import barrel_pkg::*;
(
    input  wire           clock,
    input  wire           rst_n,
    input  wire           block_end,
    input  wire           load,
    input  thread_id_t    load_thread,
    input  block_count_t  load_count,
    output thread_id_t    read_thread_bbc,
    output logic          load_pending,
    output count_report_t report
);

    thread_id_t   read_thread_mem;
    thread_id_t   write_thread;
    block_count_t read_count;
    logic         pipe_write;
    state_write_t pipe_entry;
    state_write_t load_entry;
    logic         ram_write;
    state_write_t ram_entry;

    assign load_entry.thread = load_thread;
    assign load_entry.count  = load_count;

    // ==============================
    // Thread sequencing
    // ==============================

    thread_stage_addressing addressing (
        .clock           (clock),
        .rst_n           (rst_n),
        .read_thread_mem (read_thread_mem),
        .read_thread_bbc (read_thread_bbc),   // block_end belongs to this thread
        .write_thread    (write_thread)
    );

    // ==============================
    // State and counting
    // ==============================

    thread_state_ram state_ram (
        .clock       (clock),
        .read_thread (read_thread_mem),
        .read_count  (read_count),
        .write       (ram_write),
        .write_entry (ram_entry)
    );

    block_count_pipeline counter (
        .clock        (clock),
        .rst_n        (rst_n),
        .read_count   (read_count),
        .block_end    (block_end),
        .write_thread (write_thread),
        .pipe_write   (pipe_write),
        .pipe_entry   (pipe_entry),
        .report       (report)
    );

    state_write_arbiter arbiter (
        .clock        (clock),
        .rst_n        (rst_n),
        .pipe_write   (pipe_write),
        .pipe_entry   (pipe_entry),
        .load         (load),
        .load_entry   (load_entry),
        .load_pending (load_pending),
        .write        (ram_write),
        .write_entry  (ram_entry)
    );

endmodule

`default_nettype wire

// File: verilog/block_count_pipeline.sv
// Per-thread basic-block count pipeline
// Increment at the block-counter stage, carry, write-back request and report

`default_nettype none

module block_count_pipeline
    import barrel_pkg::*;
(
    input  wire           clock,
    input  wire           rst_n,
    input  block_count_t  read_count,
    input  wire           block_end,
    input  thread_id_t    write_thread,
    output logic          pipe_write,
    output state_write_t  pipe_entry,
    output count_report_t report
);

    localparam int DEPTH = 3;   // T1 to T4

    block_count_t count_pipe [DEPTH];
    logic [DEPTH-1:0] inc_pipe;
    logic [3:0]       valid_shift;
    block_count_t     bbc_count;

    // ==============================
    // Block-counter stage
    // ==============================

    // Count wraps silently at the field width
    assign bbc_count = block_end ? read_count + 1'b1 : read_count;

    // ==============================
    // Carry to write-back
    // ==============================

    // Payload only
    always_ff @(posedge clock) begin
        count_pipe[0] <= bbc_count;
        for (int i = 1; i < DEPTH; i++) begin
            count_pipe[i] <= count_pipe[i-1];
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            inc_pipe    <= '0;
            valid_shift <= '0;
        end else begin
            inc_pipe    <= {inc_pipe[DEPTH-2:0], block_end};   // Marks changed counts
            valid_shift <= {valid_shift[2:0], 1'b1};          // Fill marker
        end
    end

    // ==============================
    // Write-back
    // ==============================

    // Unchanged counts need no write, which frees the port for host loads
    assign pipe_write        = inc_pipe[DEPTH-1];
    assign pipe_entry.thread = write_thread;
    assign pipe_entry.count  = count_pipe[DEPTH-1];

    assign report.valid  = valid_shift[3];
    assign report.thread = write_thread;
    assign report.count  = count_pipe[DEPTH-1];

endmodule

`default_nettype wire

// File: verilog/state_write_arbiter.sv
// Write port arbiter for the thread state memory
// Pipeline write-back has priority, host loads wait in a one-entry slot

`default_nettype none

module state_write_arbiter
    import barrel_pkg::*;
(
    input  wire          clock,
    input  wire          rst_n,
    input  wire          pipe_write,
    input  state_write_t pipe_entry,
    input  wire          load,
    input  state_write_t load_entry,
    output logic         load_pending,
    output logic         write,
    output state_write_t write_entry
);

    state_write_t pending_entry;
    logic         pending_valid;
    logic         capture;
    logic         retire;

    // Slot takes a load only when empty, a second strobe is lost
    assign capture = load && !pending_valid;
    assign retire  = pending_valid && !pipe_write;   // Port free this cycle

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pending_valid <= 1'b0;
        end else if (capture) begin
            pending_valid <= 1'b1;
        end else if (retire) begin
            pending_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (capture) begin
            pending_entry <= load_entry;
        end
    end

    // ==============================
    // Port select
    // ==============================

    assign write        = pipe_write || pending_valid;
    assign write_entry  = pipe_write ? pipe_entry : pending_entry;
    assign load_pending = pending_valid;

endmodule

`default_nettype wire

// File: verilog/thread_state_ram.sv
// Per-thread block count memory
// One registered read port, one write port

`default_nettype none

`include "barrel_config.svh"

module thread_state_ram
    import barrel_pkg::*;
(
    input  wire          clock,
    input  thread_id_t   read_thread,
    output block_count_t read_count,
    input  wire          write,
    input  state_write_t write_entry
);

    localparam int ENTRIES = `BARREL_THREAD_COUNT;

    block_count_t mem [ENTRIES];

    // Read and write threads are always apart, so no bypass is needed
    always_ff @(posedge clock) begin
        if (write) begin
            mem[write_entry.thread] <= write_entry.count;
        end
        read_count <= mem[read_thread];   // Data one cycle after address
    end

endmodule

`default_nettype wire

// File: verilog/thread_stage_addressing.sv
// Thread numbers for each pipeline stage
// Delays the current thread to the memory-read and block-counter stages

`default_nettype none

`include "barrel_config.svh"

module thread_stage_addressing
    import barrel_pkg::*;
(
    input  wire        clock,
    input  wire        rst_n,
    output thread_id_t read_thread_mem,
    output thread_id_t read_thread_bbc,
    output thread_id_t write_thread
);

    localparam int unsigned THREADS = `BARREL_THREAD_COUNT;
    localparam int unsigned INITIAL = `BARREL_INITIAL_THREAD;

    // Start values follow the rotation backwards from the initial thread
    localparam thread_id_t DELAY_1_INIT = thread_id_t'((INITIAL + THREADS - 1) % THREADS);
    localparam thread_id_t DELAY_2_INIT = thread_id_t'((INITIAL + THREADS - 2) % THREADS);
    localparam thread_id_t DELAY_3_INIT = thread_id_t'((INITIAL + THREADS - 3) % THREADS);
    localparam thread_id_t DELAY_4_INIT = thread_id_t'((INITIAL + THREADS - 4) % THREADS);

    thread_id_t current_thread;
    thread_id_t next_thread;
    thread_id_t read_delay_1;
    thread_id_t read_delay_2;
    thread_id_t read_delay_3;
    thread_id_t read_delay_4;

    thread_counter tid (
        .clock          (clock),
        .rst_n          (rst_n),
        .current_thread (current_thread),
        .next_thread    (next_thread)
    );

    // ==============================
    // Stage delays
    // ==============================

    // Memory read at T0, block counter at T1, write-back at T4.
    // The block-counter stage holds the thread whose data left the RAM
    // this cycle, so it trails the memory read address by one.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            read_delay_1 <= DELAY_1_INIT;
            read_delay_2 <= DELAY_2_INIT;
            read_delay_3 <= DELAY_3_INIT;
            read_delay_4 <= DELAY_4_INIT;
        end else begin
            read_delay_1 <= current_thread;
            read_delay_2 <= read_delay_1;
            read_delay_3 <= read_delay_2;
            read_delay_4 <= read_delay_3;
        end
    end

    assign read_thread_mem = read_delay_3;   // T0
    assign read_thread_bbc = read_delay_4;   // T1
    assign write_thread    = next_thread;    // T4, four past the read

endmodule

`default_nettype wire

// File: verilog/thread_counter.sv
// Round-robin thread counter
// Current thread register and its wrapped successor

`default_nettype none

`include "barrel_config.svh"

module thread_counter
    import barrel_pkg::*;
(
    input  wire        clock,
    input  wire        rst_n,
    output thread_id_t current_thread,
    output thread_id_t next_thread
);

    localparam thread_id_t LAST_THREAD    = thread_id_t'(`BARREL_THREAD_COUNT - 1);
    localparam thread_id_t INITIAL_THREAD = thread_id_t'(`BARREL_INITIAL_THREAD);

    // Successor wraps at the thread count, not at the field width
    always_comb begin
        if (current_thread == LAST_THREAD) begin
            next_thread = '0;
        end else begin
            next_thread = current_thread + 1'b1;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            current_thread <= INITIAL_THREAD;
        end else begin
            current_thread <= next_thread;   // One thread per clock
        end
    end

endmodule

`default_nettype wire

// File: verilog/barrel_pkg.sv
// Shared types for the barrel block counter
// Thread number, block count, state write request and write-back report

`default_nettype none

`include "barrel_config.svh"

package barrel_pkg;

    // ==============================
    // Scalars
    // ==============================

    typedef logic [`BARREL_THREAD_ADDR_WIDTH-1:0] thread_id_t;
    typedef logic [`BARREL_COUNT_WIDTH-1:0]       block_count_t;

    // ==============================
    // Bundles
    // ==============================

    // One write into the per-thread state memory
    typedef struct packed {
        thread_id_t   thread;   // Entry to write
        block_count_t count;    // New count
    } state_write_t;

    // Count seen at write-back, one thread per cycle
    typedef struct packed {
        logic         valid;    // Pipeline has filled since reset
        thread_id_t   thread;   // Thread at write-back
        block_count_t count;    // Its count after this pass
    } count_report_t;

endpackage

`default_nettype wire

// File: include/barrel_config.svh
// Build-time sizes for the barrel thread sequencer and block counter
// Thread count, thread number width, count width, initial thread

`ifndef BARREL_CONFIG_SVH
`define BARREL_CONFIG_SVH

// ==============================
// Thread sequencing
// ==============================

`define BARREL_THREAD_COUNT       8   // Must stay at 5 or more
`define BARREL_THREAD_ADDR_WIDTH  3   // Enough bits for the thread count
`define BARREL_INITIAL_THREAD     0   // Current thread right after reset

// ==============================
// Block counting
// ==============================

`define BARREL_COUNT_WIDTH        16  // Per-thread basic-block count, wraps

`endif
